// File: Bender.yml
package:
  name: iq_top

sources:
  - include_dirs:
      - source
    files:
      - source/iq_types_pkg.sv
      - source/iq_lanes_pkg.sv
      - source/iq_write_ptrs.sv
      - source/iq_read_ptrs.sv
      - source/iq_occupancy.sv
      - source/iq_storage.sv
      - source/iq_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/iq_top_assertions.sv
      - verif/iq_top_tb.sv

// File: iq_top.f
+incdir+source
source/iq_types_pkg.sv
source/iq_lanes_pkg.sv
source/iq_write_ptrs.sv
source/iq_read_ptrs.sv
source/iq_occupancy.sv
source/iq_storage.sv
source/iq_top.sv
verif/iq_top_assertions.sv
verif/iq_top_tb.sv

// File: source/iq_lanes_pkg.sv
`include "iq_settings.svh"

package iq_lanes_pkg;

  import iq_types_pkg::*;

  // ====================
  // Lane bundles
  // ====================

  typedef iq_entry_t [`IQ_WRITE_LANES-1:0] iq_write_bundle_t;
  typedef iq_entry_t [`IQ_READ_LANES-1:0] iq_read_bundle_t;

  typedef iq_slot_t [`IQ_WRITE_LANES-1:0] iq_wr_addr_t;
  typedef iq_slot_t [`IQ_READ_LANES-1:0] iq_rd_addr_t;

  // Entries written this cycle, count is zero when nothing was accepted
  typedef struct packed {
    logic      thread;
    iq_count_t count;
  } iq_push_t;

  // Entries consumed this cycle from the thread being shown
  typedef struct packed {
    logic      thread;
    iq_count_t count;
  } iq_pop_t;

endpackage

// File: source/iq_occupancy.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_occupancy
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  iq_push_t                  push,
  input  iq_pop_t                   pop,
  input  logic                      write_thread,
  input  logic                      except,
  input  logic                      except_thread,
  output logic                      fetch_stall,
  output logic [`IQ_READ_LANES-1:0] read_avail
);

  iq_fill_t fill [2];
  iq_fill_t fill_next [2];
  iq_fill_t add_cnt;
  iq_fill_t sub_cnt;

  // ====================
  // Fill update
  // ====================

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      add_cnt = (push.thread == t[0]) ? iq_fill_t'(push.count) : '0;
      sub_cnt = (pop.thread == t[0]) ? iq_fill_t'(pop.count) : '0;
      if (except && except_thread == t[0]) begin
        fill_next[t] = '0;
      end else begin
        fill_next[t] = fill[t] + add_cnt - sub_cnt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill[0] <= '0;
      fill[1] <= '0;
    end else begin
      fill[0] <= fill_next[0];
      fill[1] <= fill_next[1];
    end
  end

  // ====================
  // Stall and availability
  // ====================

  assign fetch_stall = fill[write_thread] >= iq_fill_t'(`IQ_STALL_LEVEL);

  always_comb begin
    for (int i = 0; i < `IQ_READ_LANES; i++) begin
      read_avail[i] = fill[pop.thread] > iq_fill_t'(i);
    end
  end

endmodule

// File: source/iq_read_ptrs.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_read_ptrs
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_clk_en,
  input  logic                      read_thread,
  input  logic [`IQ_READ_LANES-1:0] read_en,
  input  logic                      except,
  input  logic                      except_thread,
  output iq_pop_t                   pop,
  output iq_rd_addr_t               rd_addr
);

  logic      cur_thread;
  iq_slot_t  rd_ptr [2];
  iq_count_t rd_count;

  always_comb begin
    rd_count = '0;
    for (int i = 0; i < `IQ_READ_LANES; i++) begin
      if (read_en[i] && rd_count == iq_count_t'(i)) begin
        rd_count = iq_count_t'(i + 1);
      end
    end
  end

  assign pop.thread = cur_thread;
  assign pop.count  = read_clk_en ? rd_count : '0;

  // The shown thread's lanes start at its read pointer
  always_comb begin
    for (int i = 0; i < `IQ_READ_LANES; i++) begin
      rd_addr[i] = rd_ptr[cur_thread] + iq_slot_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_thread <= 1'b0;
    end else begin
      cur_thread <= read_thread;
    end
    for (int t = 0; t < 2; t++) begin
      if (rst || (except && except_thread == t[0])) begin
        rd_ptr[t] <= '0;
      end else if (cur_thread == t[0]) begin
        rd_ptr[t] <= rd_ptr[t] + iq_slot_t'(pop.count);
      end
    end
  end

endmodule

// File: source/iq_settings.svh
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// ====================
// Queue geometry
// ====================

`define IQ_DEPTH        16
`define IQ_PTR_BITS     4
`define IQ_WRITE_LANES  4
`define IQ_READ_LANES   3

// ====================
// Entry fields
// ====================

`define IQ_INSTR_WIDTH  32
`define IQ_OTHER_WIDTH  8

// Leaves room for one full write group above this level
`define IQ_STALL_LEVEL  13

`endif

// File: source/iq_storage.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_storage
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
(
  input  logic             clk,
  input  logic             write_thread,
  input  iq_push_t         push,
  input  iq_wr_addr_t      wr_addr,
  input  iq_write_bundle_t write_data,
  input  logic             cur_thread,
  input  iq_rd_addr_t      rd_addr,
  output iq_read_bundle_t  read_data
);

  // One ring per thread
  iq_entry_t ring0 [`IQ_DEPTH];
  iq_entry_t ring1 [`IQ_DEPTH];

  // ====================
  // Lane writes
  // ====================

  // Lanes at or above the accepted count are left out
  always_ff @(posedge clk) begin
    for (int i = 0; i < `IQ_WRITE_LANES; i++) begin
      if (iq_count_t'(i) < push.count) begin
        if (write_thread) begin
          ring1[wr_addr[i]] <= write_data[i];
        end else begin
          ring0[wr_addr[i]] <= write_data[i];
        end
      end
    end
  end

  // ====================
  // Lane reads
  // ====================

  always_comb begin
    for (int i = 0; i < `IQ_READ_LANES; i++) begin
      if (cur_thread) begin
        read_data[i] = ring1[rd_addr[i]];
      end else begin
        read_data[i] = ring0[rd_addr[i]];
      end
    end
  end

endmodule

// File: source/iq_top.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_top
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write_wen,
  input  logic                       write_thread,
  input  logic [`IQ_WRITE_LANES-1:0] write_en,
  input  iq_write_bundle_t           write_data,
  input  logic                       read_clk_en,
  input  logic                       read_thread,
  input  logic [`IQ_READ_LANES-1:0]  read_en,
  input  logic                       except,
  input  logic                       except_thread,
  output logic                       fetch_stall,
  output logic [`IQ_READ_LANES-1:0]  read_avail,
  output iq_read_bundle_t            read_data
);

  iq_push_t    push;
  iq_pop_t     pop;
  iq_wr_addr_t wr_addr;
  iq_rd_addr_t rd_addr;

  iq_write_ptrs iq_write_ptrs_i (
    .clk           (clk),
    .rst           (rst),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_en      (write_en),
    .fetch_stall   (fetch_stall),
    .except        (except),
    .except_thread (except_thread),
    .push          (push),
    .wr_addr       (wr_addr)
  );

  iq_read_ptrs iq_read_ptrs_i (
    .clk           (clk),
    .rst           (rst),
    .read_clk_en   (read_clk_en),
    .read_thread   (read_thread),
    .read_en       (read_en),
    .except        (except),
    .except_thread (except_thread),
    .pop           (pop),
    .rd_addr       (rd_addr)
  );

  iq_occupancy iq_occupancy_i (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .pop           (pop),
    .write_thread  (write_thread),
    .except        (except),
    .except_thread (except_thread),
    .fetch_stall   (fetch_stall),
    .read_avail    (read_avail)
  );

  // The shown thread comes from the read side's registered copy
  iq_storage iq_storage_i (
    .clk          (clk),
    .write_thread (write_thread),
    .push         (push),
    .wr_addr      (wr_addr),
    .write_data   (write_data),
    .cur_thread   (pop.thread),
    .rd_addr      (rd_addr),
    .read_data    (read_data)
  );

endmodule

// File: source/iq_types_pkg.sv
`include "iq_settings.svh"

package iq_types_pkg;

  // Slot address inside one thread's ring
  typedef logic [`IQ_PTR_BITS-1:0] iq_slot_t;

  // Lanes used in one cycle, 0 up to the write lane count
  typedef logic [$clog2(`IQ_WRITE_LANES + 1)-1:0] iq_count_t;

  // Entries held by one thread, 0 up to the depth
  typedef logic [$clog2(`IQ_DEPTH + 1)-1:0] iq_fill_t;

  typedef logic [`IQ_INSTR_WIDTH-1:0] iq_instr_t;
  typedef logic [`IQ_OTHER_WIDTH-1:0] iq_other_t;

  // One queue entry as stored and shown on a read lane
  typedef struct packed {
    iq_instr_t instr;
    iq_other_t other;
  } iq_entry_t;

endpackage

// File: source/iq_write_ptrs.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_write_ptrs
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write_wen,
  input  logic                       write_thread,
  input  logic [`IQ_WRITE_LANES-1:0] write_en,
  input  logic                       fetch_stall,
  input  logic                       except,
  input  logic                       except_thread,
  output iq_push_t                   push,
  output iq_wr_addr_t                wr_addr
);

  iq_slot_t  wr_ptr [2];
  iq_count_t wr_count;

  // Count the leading ones of write_en, anything past the first gap is ignored
  always_comb begin
    wr_count = '0;
    for (int i = 0; i < `IQ_WRITE_LANES; i++) begin
      if (write_en[i] && wr_count == iq_count_t'(i)) begin
        wr_count = iq_count_t'(i + 1);
      end
    end
  end

  assign push.thread = write_thread;
  assign push.count  = (write_wen && !fetch_stall) ? wr_count : '0;

  always_comb begin
    for (int i = 0; i < `IQ_WRITE_LANES; i++) begin
      wr_addr[i] = wr_ptr[write_thread] + iq_slot_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < 2; t++) begin
      if (rst || (except && except_thread == t[0])) begin
        wr_ptr[t] <= '0;
      end else if (write_thread == t[0]) begin
        wr_ptr[t] <= wr_ptr[t] + iq_slot_t'(push.count);
      end
    end
  end

endmodule

// File: verif/iq_top_assertions.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_top_assertions
  import iq_types_pkg::*;
(
  input logic                      clk,
  input logic                      rst,
  input logic                      fetch_stall,
  input logic [`IQ_READ_LANES-1:0] read_avail,
  input iq_fill_t                  fill0,
  input iq_fill_t                  fill1
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Available lanes always start at lane 0 with no gaps
  avail_is_prefix: assert property (@(posedge clk) disable iff (rst)
    read_avail inside {3'b000, 3'b001, 3'b011, 3'b111})
    else begin
      fail_count++;
      $error("read_avail is not a prefix mask");
    end

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (!fetch_stall && read_avail == '0))
    else begin
      fail_count++;
      $error("fetch_stall or read_avail high right after reset");
    end

  fill_in_range: assert property (@(posedge clk) disable iff (rst)
    fill0 <= iq_fill_t'(`IQ_DEPTH) && fill1 <= iq_fill_t'(`IQ_DEPTH))
    else begin
      fail_count++;
      $error("thread fill above the queue depth");
    end

endmodule

bind iq_top iq_top_assertions iq_top_assertions_i (
  .clk         (clk),
  .rst         (rst),
  .fetch_stall (fetch_stall),
  .read_avail  (read_avail),
  .fill0       (iq_occupancy_i.fill[0]),
  .fill1       (iq_occupancy_i.fill[1])
);

// File: verif/iq_top_tb.sv
`timescale 1ns/1ns
`include "iq_settings.svh"

module iq_top_tb
  import iq_types_pkg::*;
  import iq_lanes_pkg::*;
();

  // The tests take about 100 cycles, so this leaves a wide margin
  localparam int max_cycles = 400;

  logic                       clk;
  logic                       rst;
  logic                       write_wen;
  logic                       write_thread;
  logic [`IQ_WRITE_LANES-1:0] write_en;
  iq_write_bundle_t           write_data;
  logic                       read_clk_en;
  logic                       read_thread;
  logic [`IQ_READ_LANES-1:0]  read_en;
  logic                       except;
  logic                       except_thread;
  logic                       fetch_stall;
  logic [`IQ_READ_LANES-1:0]  read_avail;
  iq_read_bundle_t            read_data;

  // Expected contents of each thread, oldest entry first
  iq_entry_t ref_q0 [$];
  iq_entry_t ref_q1 [$];
  logic      shown_thread;
  int        checks;
  int        errors;
  int        assert_fails;
  int        cycle_count;

  iq_top iq_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ====================
  // Reference queues
  // ====================

  function automatic int queue_size(input logic t);
    return t ? ref_q1.size() : ref_q0.size();
  endfunction

  function automatic iq_entry_t peek_entry(input logic t, input int idx);
    return t ? ref_q1[idx] : ref_q0[idx];
  endfunction

  task automatic append_entry(input logic t, input iq_entry_t e);
    if (t) ref_q1.push_back(e);
    else ref_q0.push_back(e);
  endtask

  task automatic drop_oldest(input logic t);
    if (t) void'(ref_q1.pop_front());
    else void'(ref_q0.pop_front());
  endtask

  task automatic clear_thread(input logic t);
    if (t) ref_q1.delete();
    else ref_q0.delete();
  endtask

  // Lanes in use stop at the first zero of the enable mask
  function automatic int lead_ones(input logic [3:0] m, input int width);
    int n;
    n = 0;
    while (n < width && m[n]) n++;
    return n;
  endfunction

  function automatic logic [3:0] lane_mask(input int n);
    logic [3:0] m;
    m = '0;
    for (int i = 0; i < n; i++) m[i] = 1'b1;
    return m;
  endfunction

  // ====================
  // Drivers and checks
  // ====================

  task automatic write_group(input logic thread, input logic [3:0] en);
    iq_entry_t lane_data;
    int        n;
    logic      accept;
    accept = queue_size(thread) < `IQ_STALL_LEVEL;
    n = lead_ones(en, `IQ_WRITE_LANES);
    write_wen = 1'b1;
    write_thread = thread;
    write_en = en;
    for (int i = 0; i < `IQ_WRITE_LANES; i++) begin
      lane_data.instr = $urandom;
      lane_data.other = iq_other_t'($urandom);
      write_data[i] = lane_data;
      if (accept && i < n) append_entry(thread, lane_data);
    end
    @(posedge clk);
    #5;
    write_wen = 1'b0;
    write_en = '0;
  endtask

  // Never pops more than the shown thread has available
  task automatic pop_group(input logic [2:0] en);
    int         n;
    int         avail_n;
    logic [3:0] mask;
    n = lead_ones({1'b0, en}, `IQ_READ_LANES);
    avail_n = queue_size(shown_thread);
    if (avail_n > `IQ_READ_LANES) avail_n = `IQ_READ_LANES;
    if (n > avail_n) begin
      n = avail_n;
      mask = lane_mask(n);
      read_en = mask[`IQ_READ_LANES-1:0];
    end else begin
      read_en = en;
    end
    read_clk_en = 1'b1;
    for (int k = 0; k < n; k++) drop_oldest(shown_thread);
    @(posedge clk);
    #5;
    read_clk_en = 1'b0;
    read_en = '0;
  endtask

  task automatic show_thread(input logic t);
    read_thread = t;
    @(posedge clk);
    #5;
    shown_thread = t;
  endtask

  task automatic raise_except(input logic t);
    except = 1'b1;
    except_thread = t;
    @(posedge clk);
    #5;
    except = 1'b0;
    clear_thread(t);
  endtask

  task automatic check_outputs(input string name);
    int                       avail_n;
    logic [3:0]               avail_mask;
    logic [`IQ_READ_LANES-1:0] exp_avail;
    logic                     exp_stall;
    iq_entry_t                exp_entry;
    @(negedge clk);
    avail_n = queue_size(shown_thread);
    if (avail_n > `IQ_READ_LANES) avail_n = `IQ_READ_LANES;
    avail_mask = lane_mask(avail_n);
    exp_avail = avail_mask[`IQ_READ_LANES-1:0];
    exp_stall = queue_size(write_thread) >= `IQ_STALL_LEVEL;
    checks++;
    assert (read_avail == exp_avail) else begin
      errors++;
      $display("error %s: read_avail expected %b actual %b", name, exp_avail, read_avail);
    end
    assert (fetch_stall == exp_stall) else begin
      errors++;
      $display("error %s: fetch_stall expected %b actual %b", name, exp_stall, fetch_stall);
    end
    for (int i = 0; i < avail_n; i++) begin
      exp_entry = peek_entry(shown_thread, i);
      assert (read_data[i] == exp_entry) else begin
        errors++;
        $display("error %s: read_data lane %0d expected %h actual %h",
                 name, i, exp_entry, read_data[i]);
      end
    end
    @(posedge clk);
    #5;
  endtask

  task automatic drain_shown(input string name);
    while (queue_size(shown_thread) > 0) begin
      pop_group(3'b111);
      check_outputs(name);
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic reset_values();
    check_outputs("reset_values");
  endtask

  task automatic write_readback();
    for (int n = 1; n <= `IQ_WRITE_LANES; n++) begin
      write_group(1'b0, lane_mask(n));
      check_outputs("write_readback");
    end
  endtask

  // Enough traffic goes through thread 0 here that both pointers pass slot 15
  task automatic prefix_and_wrap();
    write_group(1'b0, 4'b1101);
    check_outputs("prefix_and_wrap");
    pop_group(3'b101);
    check_outputs("prefix_and_wrap");
    repeat (3) begin
      pop_group(3'b111);
      check_outputs("prefix_and_wrap");
      pop_group(3'b111);
      check_outputs("prefix_and_wrap");
      write_group(1'b0, 4'b1111);
      check_outputs("prefix_and_wrap");
    end
    drain_shown("prefix_and_wrap");
  endtask

  task automatic stall_at_level();
    repeat (3) begin
      write_group(1'b0, 4'b1111);
      check_outputs("stall_at_level");
    end
    write_group(1'b0, 4'b0001);
    check_outputs("stall_at_level");
    write_group(1'b0, 4'b1111);
    check_outputs("stall_at_level");
    drain_shown("stall_at_level");
  endtask

  task automatic thread_independence();
    write_group(1'b0, 4'b1111);
    write_group(1'b0, 4'b0111);
    write_group(1'b1, 4'b1111);
    write_group(1'b1, 4'b0011);
    check_outputs("thread_independence");
    show_thread(1'b1);
    check_outputs("thread_independence");
    pop_group(3'b011);
    check_outputs("thread_independence");
    show_thread(1'b0);
    check_outputs("thread_independence");
  endtask

  task automatic flush_thread1();
    show_thread(1'b1);
    check_outputs("flush_thread1");
    raise_except(1'b1);
    check_outputs("flush_thread1");
    write_group(1'b1, 4'b0011);
    check_outputs("flush_thread1");
    show_thread(1'b0);
    check_outputs("flush_thread1");
    pop_group(3'b111);
    check_outputs("flush_thread1");
  endtask

  initial begin
    void'($urandom(83));
    clk = 1'b0;
    rst = 1'b1;
    write_wen = 1'b0;
    write_thread = 1'b0;
    write_en = '0;
    write_data = '0;
    read_clk_en = 1'b0;
    read_thread = 1'b0;
    read_en = '0;
    except = 1'b0;
    except_thread = 1'b0;
    shown_thread = 1'b0;
    checks = 0;
    errors = 0;
    assert_fails = 0;
    cycle_count = 0;
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;

    reset_values();
    write_readback();
    prefix_and_wrap();
    stall_at_level();
    thread_independence();
    flush_thread1();

    assert_fails = iq_top_i.iq_top_assertions_i.fail_count;
    $display("checks run %0d, errors %0d, assertion failures %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
